// File: Makefile
TOP = engine_alu_ops_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/engine_alu_ops_tb.sv
// --------------------
// ALU ops engine testbench
// Directed tests checked against a model of the ALU rules
// --------------------

`timescale 1ns/100ps

module engine_alu_ops_tb;

    localparam int FIFO_DEPTH   = 32;
    localparam int PROG_THRESH  = 16;
    localparam int BP_MAX_WORDS = 32;
    localparam int DRAIN_LIMIT  = 64;
    // Words sent over all tests with the backpressure burst at its bound
    localparam int WORDS_PLANNED = 6 * 8 + 8 + 8 + 7 + BP_MAX_WORDS;
    localparam int WATCHDOG_NS   = WORDS_PLANNED * 100 + 2000;

    logic                    ap_clk = 1'b0;
    logic                    areset_alu_ops_engine;
    logic                    descriptor_in_valid;
    alu_ops_pkg::count_t     descriptor_in_count;
    logic                    response_memory_in_valid;
    alu_ops_pkg::cfg_index_e response_memory_in_index;
    alu_ops_pkg::cfg_word_u  response_memory_in_data;
    logic                    response_engine_in_valid;
    alu_ops_pkg::word_t      response_engine_in_data;
    logic                    response_engine_in_prog_full;
    logic                    request_engine_out_rd_en;
    logic                    request_engine_out_valid;
    alu_ops_pkg::word_t      request_engine_out_data;
    logic                    done_out;

    int                      seed = 32'h4e27_7335;
    int                      value_errors = 0;
    int                      other_errors = 0;
    alu_ops_pkg::word_t      exp_q[$];
    logic [2:0]              model_op;
    logic                    model_swap;
    alu_ops_pkg::word_t      model_const;

    always #2 ap_clk = ~ap_clk;

    engine_alu_ops #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) engine_alu_ops_i (
        .ap_clk                       (ap_clk),
        .areset_alu_ops_engine        (areset_alu_ops_engine),
        .descriptor_in_valid          (descriptor_in_valid),
        .descriptor_in_count          (descriptor_in_count),
        .response_memory_in_valid     (response_memory_in_valid),
        .response_memory_in_index     (response_memory_in_index),
        .response_memory_in_data      (response_memory_in_data),
        .response_engine_in_valid     (response_engine_in_valid),
        .response_engine_in_data      (response_engine_in_data),
        .response_engine_in_prog_full (response_engine_in_prog_full),
        .request_engine_out_rd_en     (request_engine_out_rd_en),
        .request_engine_out_valid     (request_engine_out_valid),
        .request_engine_out_data      (request_engine_out_data),
        .done_out                     (done_out)
    );

    // --------------------
    // Model and compares
    // --------------------
    // Result is op(data, constant) with the operands exchanged when swap is set
    function automatic alu_ops_pkg::word_t expected_result(
        input logic [2:0]         op,
        input logic               swap,
        input alu_ops_pkg::word_t d,
        input alu_ops_pkg::word_t c
    );
        alu_ops_pkg::word_t x;
        alu_ops_pkg::word_t y;
        alu_ops_pkg::word_t r;
        x = swap ? c : d;
        y = swap ? d : c;
        case (op)
            3'd1:    r = x - y;
            3'd2:    r = x * y;
            3'd3:    r = (x <= y) ? x : y;
            3'd4:    r = (x >= y) ? x : y;
            3'd5:    r = x ^ y;
            default: r = x + y;
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input alu_ops_pkg::word_t got,
                              input alu_ops_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        other_errors++;
    endtask

    // --------------------
    // Drivers
    // --------------------
    task automatic configure(input logic [2:0] op, input logic swap,
                             input alu_ops_pkg::word_t c);
        alu_ops_pkg::cfg_word_u w;
        w.raw = {op, swap, 28'h0};
        @(negedge ap_clk);
        response_memory_in_valid = 1'b1;
        response_memory_in_index = alu_ops_pkg::CFG_OP;
        response_memory_in_data  = w;
        @(negedge ap_clk);
        w.raw = c;
        response_memory_in_index = alu_ops_pkg::CFG_CONST;
        response_memory_in_data  = w;
        @(negedge ap_clk);
        response_memory_in_valid = 1'b0;
        model_op    = op;
        model_swap  = swap;
        model_const = c;
    endtask

    task automatic start_job(input alu_ops_pkg::count_t n);
        @(negedge ap_clk);
        descriptor_in_valid = 1'b1;
        descriptor_in_count = n;
        @(negedge ap_clk);
        descriptor_in_valid = 1'b0;
    endtask

    // A word the engine should keep also queues its expected result
    task automatic send_word(input alu_ops_pkg::word_t w, input logic kept);
        @(negedge ap_clk);
        response_engine_in_valid = 1'b1;
        response_engine_in_data  = w;
        @(negedge ap_clk);
        response_engine_in_valid = 1'b0;
        if (kept) begin
            exp_q.push_back(expected_result(model_op, model_swap, w, model_const));
        end
    endtask

    task automatic send_random_words(input int n);
        for (int i = 0; i < n; i++) begin
            send_word($random(seed), 1'b1);
        end
    endtask

    task automatic take_result();
        if (exp_q.size() == 0) begin
            report_failure("result arrived with none expected");
        end else begin
            check_word("request_engine_out_data", request_engine_out_data, exp_q.pop_front());
        end
    endtask

    // Reads until n results arrive, then keeps reading a while to catch strays
    task automatic drain_results(input int n);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < n && idle < DRAIN_LIMIT) begin
            @(negedge ap_clk);
            if (request_engine_out_valid) begin
                take_result();
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            request_engine_out_rd_en = 1'b1;
        end
        if (got < n) begin
            report_failure($sformatf("only %0d of %0d results arrived", got, n));
        end
        request_engine_out_rd_en = 1'b1;
        repeat (4) begin
            @(negedge ap_clk);
            if (request_engine_out_valid) begin
                report_failure("more results than the job produced");
            end
        end
        request_engine_out_rd_en = 1'b0;
        repeat (2) begin
            @(negedge ap_clk);
            if (request_engine_out_valid) begin
                report_failure("more results than the job produced");
            end
        end
    endtask

    // Single rd_en pulse whose valid must come two cycles later
    task automatic read_one_timed();
        @(negedge ap_clk);
        request_engine_out_rd_en = 1'b1;
        @(negedge ap_clk);
        request_engine_out_rd_en = 1'b0;
        check_level("request_engine_out_valid", request_engine_out_valid, 1'b0);
        @(negedge ap_clk);
        check_level("request_engine_out_valid", request_engine_out_valid, 1'b1);
        if (request_engine_out_valid) begin
            take_result();
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done_out && n < DRAIN_LIMIT) begin
            @(negedge ap_clk);
            n++;
        end
        if (!done_out) begin
            report_failure("done_out never rose");
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_unconfigured_drop();
        start_job(16'd4);
        for (int i = 0; i < 3; i++) begin
            send_word($random(seed), 1'b0);
        end
        configure(3'd0, 1'b0, $random(seed));
        send_random_words(4);
        drain_results(4);
        wait_done();
    endtask

    task automatic test_each_op();
        for (int op = 0; op < 6; op++) begin
            configure(op[2:0], 1'b0, $random(seed));
            start_job(16'd8);
            send_random_words(8);
            drain_results(8);
        end
    endtask

    task automatic test_swap();
        configure(3'd1, 1'b1, 32'd100);
        start_job(16'd4);
        send_word(32'd5, 1'b1);
        send_word(32'd40, 1'b1);
        send_random_words(2);
        drain_results(4);
        // Reserved code 7 runs as ADD
        configure(3'd7, 1'b0, $random(seed));
        start_job(16'd4);
        send_random_words(4);
        drain_results(4);
    endtask

    task automatic test_done();
        configure(3'd0, 1'b0, $random(seed));
        start_job(16'd5);
        send_random_words(5);
        repeat (10) @(negedge ap_clk);
        check_level("done_out", done_out, 1'b0);
        drain_results(5);
        wait_done();
        repeat (5) begin
            @(negedge ap_clk);
            check_level("done_out", done_out, 1'b1);
        end
        start_job(16'd3);
        @(negedge ap_clk);
        check_level("done_out", done_out, 1'b0);
        send_random_words(3);
        drain_results(3);
        wait_done();
        // Empty job
        start_job(16'd0);
        @(negedge ap_clk);
        check_level("done_out", done_out, 1'b0);
        wait_done();
        drain_results(0);
    endtask

    task automatic test_backpressure();
        int sent;
        sent = 0;
        configure(3'd5, 1'b0, $random(seed));
        start_job(16'd64);
        while (!response_engine_in_prog_full && sent < BP_MAX_WORDS) begin
            send_word($random(seed), 1'b1);
            sent++;
        end
        if (!response_engine_in_prog_full) begin
            report_failure("prog_full never rose with reads held off");
        end
        repeat (8) @(negedge ap_clk);
        for (int i = 0; i < sent; i++) begin
            read_one_timed();
        end
        drain_results(0);
        check_level("response_engine_in_prog_full", response_engine_in_prog_full, 1'b0);
    endtask

    // --------------------
    // Main sequence and watchdog
    // --------------------
    initial begin
        areset_alu_ops_engine    = 1'b1;
        descriptor_in_valid      = 1'b0;
        descriptor_in_count      = '0;
        response_memory_in_valid = 1'b0;
        response_memory_in_index = alu_ops_pkg::CFG_OP;
        response_memory_in_data  = '0;
        response_engine_in_valid = 1'b0;
        response_engine_in_data  = '0;
        request_engine_out_rd_en = 1'b0;
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_alu_ops_engine = 1'b0;
        check_level("done_out", done_out, 1'b0);
        check_level("request_engine_out_valid", request_engine_out_valid, 1'b0);
        check_level("response_engine_in_prog_full", response_engine_in_prog_full, 1'b0);

        test_unconfigured_drop();
        test_each_op();
        test_swap();
        test_done();
        test_backpressure();

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule : engine_alu_ops_tb

// File: hdl/alu_ops_config_store.sv
// --------------------
// ALU ops configuration store
// Captures the operation word and the constant word from the memory
// response channel and holds them for the datapath
// --------------------

`timescale 1ns/100ps

module alu_ops_config_store (
    input  logic                    ap_clk,
    input  logic                    areset_alu_ops_engine,
    input  logic                    mem_valid,
    input  alu_ops_pkg::cfg_index_e mem_index,
    input  alu_ops_pkg::cfg_word_u  mem_data,
    output logic                    cfg_ready,
    output alu_ops_pkg::alu_op_e    cfg_op,
    output logic                    cfg_swap,
    output alu_ops_pkg::word_t      cfg_constant
);

    logic                 seen_op;
    logic                 seen_const;
    logic                 wr_op;
    logic                 wr_const;
    alu_ops_pkg::alu_op_e op_decoded;

    // --------------------
    // Word decode
    // --------------------
    assign wr_op    = mem_valid & (mem_index == alu_ops_pkg::CFG_OP);
    assign wr_const = mem_valid & (mem_index == alu_ops_pkg::CFG_CONST);

    // Reserved codes fold onto ADD
    always_comb begin
        if (mem_data.op.alu_op > alu_ops_pkg::ALU_XOR) begin
            op_decoded = alu_ops_pkg::ALU_ADD;
        end else begin
            op_decoded = mem_data.op.alu_op;
        end
    end

    // --------------------
    // Configuration registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            seen_op    <= 1'b0;
            seen_const <= 1'b0;
            cfg_op     <= alu_ops_pkg::ALU_ADD;
            cfg_swap   <= 1'b0;
        end else begin
            if (wr_op) begin
                seen_op  <= 1'b1;
                cfg_op   <= op_decoded;
                cfg_swap <= mem_data.op.swap;
            end
            if (wr_const) begin
                seen_const <= 1'b1;
            end
        end
    end

    // Constant register
    always_ff @(posedge ap_clk) begin
        if (wr_const) begin
            cfg_constant <= mem_data.raw;
        end
    end

    // Ready once both words arrived since reset
    assign cfg_ready = seen_op & seen_const;

endmodule : alu_ops_config_store

// File: hdl/alu_ops_datapath.sv
// --------------------
// ALU ops datapath
// Two-stage pipeline that combines each engine word with the constant
// and tracks how many results of the current job were produced
// --------------------

`timescale 1ns/100ps

module alu_ops_datapath (
    input  logic                 ap_clk,
    input  logic                 areset_alu_ops_engine,
    input  logic                 desc_valid,
    input  alu_ops_pkg::count_t  desc_count,
    input  logic                 data_valid,
    input  alu_ops_pkg::word_t   data,
    input  logic                 cfg_ready,
    input  alu_ops_pkg::alu_op_e cfg_op,
    input  logic                 cfg_swap,
    input  alu_ops_pkg::word_t   cfg_constant,
    output logic                 result_valid,
    output alu_ops_pkg::word_t   result_data,
    output logic                 busy,
    output logic                 job_done
);

    logic                 job_seen;
    alu_ops_pkg::count_t  job_target;
    alu_ops_pkg::count_t  accepted;
    alu_ops_pkg::count_t  produced;
    logic                 accept;

    logic                 s1_valid;
    alu_ops_pkg::word_t   s1_a;
    alu_ops_pkg::word_t   s1_b;
    alu_ops_pkg::alu_op_e s1_op;

    function automatic alu_ops_pkg::word_t alu_apply(
        input alu_ops_pkg::alu_op_e op,
        input alu_ops_pkg::word_t   a,
        input alu_ops_pkg::word_t   b
    );
        alu_ops_pkg::word_t res;
        case (op)
            alu_ops_pkg::ALU_SUB: res = a - b;
            alu_ops_pkg::ALU_MUL: res = a * b;
            alu_ops_pkg::ALU_MIN: res = (a < b) ? a : b;
            alu_ops_pkg::ALU_MAX: res = (a > b) ? a : b;
            alu_ops_pkg::ALU_XOR: res = a ^ b;
            default:              res = a + b;
        endcase
        return res;
    endfunction

    // --------------------
    // Job tracking
    // --------------------
    // Words beyond the job count or before configuration are dropped
    assign accept = data_valid & cfg_ready & job_seen & (accepted != job_target);

    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            job_seen   <= 1'b0;
            job_target <= '0;
            accepted   <= '0;
            produced   <= '0;
        end else if (desc_valid) begin
            job_seen   <= 1'b1;
            job_target <= desc_count;
            accepted   <= '0;
            produced   <= '0;
        end else begin
            if (accept) begin
                accepted <= accepted + 1'b1;
            end
            if (result_valid) begin
                produced <= produced + 1'b1;
            end
        end
    end

    assign job_done = job_seen & (produced == job_target);

    // --------------------
    // Stage one, operand order
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge ap_clk) begin
        s1_a  <= cfg_swap ? cfg_constant : data;
        s1_b  <= cfg_swap ? data : cfg_constant;
        s1_op <= cfg_op;
    end

    // --------------------
    // Stage two, operation
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        result_data <= alu_apply(s1_op, s1_a, s1_b);
    end

    assign busy = s1_valid | result_valid;

endmodule : alu_ops_datapath

// File: hdl/alu_ops_pkg.sv
// --------------------
// ALU ops engine package
// Shared widths, operation codes and the configuration word layout
// --------------------

package alu_ops_pkg;

    localparam int WORD_WIDTH  = 32;
    localparam int COUNT_WIDTH = 16;

    typedef logic [WORD_WIDTH-1:0]  word_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // --------------------
    // ALU operation codes
    // --------------------
    // Codes 6 and 7 are reserved and run as ALU_ADD
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_MUL = 3'd2,
        ALU_MIN = 3'd3,
        ALU_MAX = 3'd4,
        ALU_XOR = 3'd5
    } alu_op_e;

    // Which configuration word a memory response carries
    typedef enum logic {
        CFG_OP    = 1'b0,
        CFG_CONST = 1'b1
    } cfg_index_e;

    // --------------------
    // Configuration word
    // --------------------
    // Operation word layout, MSB first
    typedef struct packed {
        alu_op_e                 alu_op;
        logic                    swap;
        logic [WORD_WIDTH-5:0]   reserved;
    } cfg_op_view_t;

    // Same memory word read as a constant or as an operation word
    typedef union packed {
        word_t        raw;
        cfg_op_view_t op;
    } cfg_word_u;

endpackage : alu_ops_pkg

// File: hdl/alu_ops_request_fifo.sv
// --------------------
// ALU ops request FIFO
// Circular buffer for results with a registered read port and
// empty and programmable-full flags taken from the fill count
// --------------------

`timescale 1ns/100ps

module alu_ops_request_fifo #(
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic               ap_clk,
    input  logic               areset_alu_ops_engine,
    input  logic               wr_en,
    input  alu_ops_pkg::word_t wr_data,
    input  logic               rd_en,
    output logic               rd_valid,
    output alu_ops_pkg::word_t rd_data,
    output logic               empty,
    output logic               prog_full
);

    localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int FILL_W = ADDR_W + 1;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FIFO_DEPTH - 1);
    localparam logic [FILL_W-1:0] FULL_FILL = FILL_W'(FIFO_DEPTH);
    localparam logic [FILL_W-1:0] PROG_FILL = FILL_W'(PROG_THRESH);

    alu_ops_pkg::word_t mem [FIFO_DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [FILL_W-1:0] fill;
    logic              do_wr;
    logic              do_rd;

    // Writes into a full buffer are lost
    assign do_wr = wr_en & (fill != FULL_FILL);
    assign do_rd = rd_en & (fill != '0);

    // --------------------
    // Pointers and fill
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                fill <= fill + 1'b1;
            end else if (do_rd && !do_wr) begin
                fill <= fill - 1'b1;
            end
            rd_valid <= do_rd;
        end
    end

    // --------------------
    // Storage and read port
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    assign empty     = (fill == '0);
    assign prog_full = (fill >= PROG_FILL);

endmodule : alu_ops_request_fifo

// File: hdl/engine_alu_ops.sv
// --------------------
// ALU operations engine
// Registers the inputs, joins the configuration store, the ALU
// datapath and the request FIFO, and reports job completion
// --------------------

`timescale 1ns/100ps

module engine_alu_ops #(
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic                    ap_clk,
    input  logic                    areset_alu_ops_engine,
    input  logic                    descriptor_in_valid,
    input  alu_ops_pkg::count_t     descriptor_in_count,
    input  logic                    response_memory_in_valid,
    input  alu_ops_pkg::cfg_index_e response_memory_in_index,
    input  alu_ops_pkg::cfg_word_u  response_memory_in_data,
    input  logic                    response_engine_in_valid,
    input  alu_ops_pkg::word_t      response_engine_in_data,
    output logic                    response_engine_in_prog_full,
    input  logic                    request_engine_out_rd_en,
    output logic                    request_engine_out_valid,
    output alu_ops_pkg::word_t      request_engine_out_data,
    output logic                    done_out
);

    logic                    desc_valid_reg;
    alu_ops_pkg::count_t     desc_count_reg;
    logic                    mem_valid_reg;
    alu_ops_pkg::cfg_index_e mem_index_reg;
    alu_ops_pkg::cfg_word_u  mem_data_reg;
    logic                    eng_valid_reg;
    alu_ops_pkg::word_t      eng_data_reg;
    logic                    rd_en_reg;

    logic                    cfg_ready;
    alu_ops_pkg::alu_op_e    cfg_op;
    logic                    cfg_swap;
    alu_ops_pkg::word_t      cfg_constant;

    logic                    result_valid;
    alu_ops_pkg::word_t      result_data;
    logic                    dp_busy;
    logic                    dp_job_done;
    logic                    fifo_empty;
    logic                    fifo_prog_full;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            desc_valid_reg <= 1'b0;
            mem_valid_reg  <= 1'b0;
            eng_valid_reg  <= 1'b0;
            rd_en_reg      <= 1'b0;
        end else begin
            desc_valid_reg <= descriptor_in_valid;
            mem_valid_reg  <= response_memory_in_valid;
            eng_valid_reg  <= response_engine_in_valid;
            rd_en_reg      <= request_engine_out_rd_en;
        end
    end

    always_ff @(posedge ap_clk) begin
        desc_count_reg <= descriptor_in_count;
        mem_index_reg  <= response_memory_in_index;
        mem_data_reg   <= response_memory_in_data;
        eng_data_reg   <= response_engine_in_data;
    end

    // --------------------
    // Blocks
    // --------------------
    alu_ops_config_store config_store_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_alu_ops_engine),
        .mem_valid             (mem_valid_reg),
        .mem_index             (mem_index_reg),
        .mem_data              (mem_data_reg),
        .cfg_ready             (cfg_ready),
        .cfg_op                (cfg_op),
        .cfg_swap              (cfg_swap),
        .cfg_constant          (cfg_constant)
    );

    alu_ops_datapath datapath_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_alu_ops_engine),
        .desc_valid            (desc_valid_reg),
        .desc_count            (desc_count_reg),
        .data_valid            (eng_valid_reg),
        .data                  (eng_data_reg),
        .cfg_ready             (cfg_ready),
        .cfg_op                (cfg_op),
        .cfg_swap              (cfg_swap),
        .cfg_constant          (cfg_constant),
        .result_valid          (result_valid),
        .result_data           (result_data),
        .busy                  (dp_busy),
        .job_done              (dp_job_done)
    );

    // FIFO read register doubles as the output register
    alu_ops_request_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) request_fifo_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_alu_ops_engine),
        .wr_en                 (result_valid),
        .wr_data               (result_data),
        .rd_en                 (rd_en_reg),
        .rd_valid              (request_engine_out_valid),
        .rd_data               (request_engine_out_data),
        .empty                 (fifo_empty),
        .prog_full             (fifo_prog_full)
    );

    // --------------------
    // Output registers
    // --------------------
    // Done needs the job count reached with nothing left in flight
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            done_out                     <= 1'b0;
            response_engine_in_prog_full <= 1'b0;
        end else begin
            response_engine_in_prog_full <= fifo_prog_full;
            if (desc_valid_reg) begin
                done_out <= 1'b0;
            end else begin
                done_out <= dp_job_done & ~dp_busy & fifo_empty;
            end
        end
    end

endmodule : engine_alu_ops

// File: list.f
hdl/alu_ops_pkg.sv
hdl/alu_ops_config_store.sv
hdl/alu_ops_datapath.sv
hdl/alu_ops_request_fifo.sv
hdl/engine_alu_ops.sv
bench/engine_alu_ops_tb.sv
